// ==== data_cache.f ====
design/cache_geom_pkg.sv
design/burst_ram_pkg.sv
design/cache_tag_lookup.sv
design/cache_controller.sv
design/cache_line_store.sv
design/data_cache.sv
tb/tb_clock_gen.sv
tb/tb_burst_ram.sv
tb/tb_cache_checker.sv
tb/tb_data_cache.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_data_cache
FILELIST   := data_cache.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0
OBJ_DIR    := obj_dir
PASS_MSG   := Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/tb_data_cache.sv ====
// testbench top that applies the table rows one at a time on falling edges
// expect_hit column follows the 2-line, 32-byte-line direct mapping
`timescale 1ns/1ps
`default_nettype none

module tb_data_cache;

  localparam logic [31:0] PRELOAD_KEY = 32'h5A3C_96E1;
  localparam int WAIT_LIMIT = 200;
  localparam int ROWS = 21;

  typedef struct packed {
    logic        is_write;
    logic [31:0] addr;
    logic [3:0]  be;
    logic        expect_hit;
  } row_t;

  // op, byte address, byte enables, hit expected
  row_t stim [ROWS] = '{
    '{1'b0, 32'h000, 4'h0, 1'b0},  // cold miss line 0
    '{1'b0, 32'h004, 4'h0, 1'b1},
    '{1'b0, 32'h01C, 4'h0, 1'b1},
    '{1'b1, 32'h008, 4'h3, 1'b1},  // partial write hit
    '{1'b0, 32'h008, 4'h0, 1'b1},
    '{1'b1, 32'h124, 4'hC, 1'b0},  // write miss line 1
    '{1'b0, 32'h124, 4'h0, 1'b1},
    '{1'b0, 32'h120, 4'h0, 1'b1},
    '{1'b0, 32'h040, 4'h0, 1'b0},  // evicts dirty line 0
    '{1'b0, 32'h008, 4'h0, 1'b0},  // victim reread from RAM
    '{1'b1, 32'h7E0, 4'hF, 1'b0},  // evicts dirty line 1
    '{1'b0, 32'h124, 4'h0, 1'b0},
    '{1'b0, 32'h7E0, 4'h0, 1'b0},
    '{1'b1, 32'h010, 4'h1, 1'b1},
    '{1'b1, 32'h010, 4'h8, 1'b1},
    '{1'b0, 32'h010, 4'h0, 1'b1},
    '{1'b0, 32'h014, 4'h0, 1'b1},
    '{1'b0, 32'h7FC, 4'h0, 1'b1},
    '{1'b0, 32'h3C0, 4'h0, 1'b0},
    '{1'b0, 32'h01C, 4'h0, 1'b0},
    '{1'b0, 32'h010, 4'h0, 1'b1}
  };

  logic clk;
  logic rst;
  logic enable;
  logic command;
  logic [cache_geom_pkg::ADDR_WIDTH-1:0] address;
  cache_geom_pkg::byte_en_t byte_en;
  cache_geom_pkg::word_t data_in;
  logic expect_hit;
  cache_geom_pkg::word_t data_out;
  logic data_out_ready;
  logic busy;
  logic br_cmd;
  logic br_cmd_en;
  logic [burst_ram_pkg::RAM_ADDR_WIDTH-1:0] br_addr;
  burst_ram_pkg::beat_t br_wr_data;
  burst_ram_pkg::beat_t br_rd_data;
  logic br_rd_data_valid;
  logic br_busy;
  int data_errors;
  int protocol_errors;
  int timeout_errors;

  tb_clock_gen clock_gen_i (.clk(clk), .rst(rst));

  data_cache dut_i (
    .clk(clk), .rst(rst), .enable(enable), .command(command), .address(address),
    .byte_en(byte_en), .data_in(data_in), .data_out(data_out),
    .data_out_ready(data_out_ready), .busy(busy), .br_cmd(br_cmd), .br_cmd_en(br_cmd_en),
    .br_addr(br_addr), .br_wr_data(br_wr_data), .br_rd_data(br_rd_data),
    .br_rd_data_valid(br_rd_data_valid), .br_busy(br_busy)
  );

  tb_burst_ram #(.PRELOAD_KEY(PRELOAD_KEY)) ram_i (
    .clk(clk), .rst(rst), .br_cmd(br_cmd), .br_cmd_en(br_cmd_en), .br_addr(br_addr),
    .br_wr_data(br_wr_data), .br_rd_data(br_rd_data),
    .br_rd_data_valid(br_rd_data_valid), .br_busy(br_busy)
  );

  tb_cache_checker #(.PRELOAD_KEY(PRELOAD_KEY)) checker_i (
    .clk(clk), .rst(rst), .enable(enable), .command(command), .address(address),
    .byte_en(byte_en), .data_in(data_in), .expect_hit(expect_hit), .busy(busy),
    .data_out(data_out), .data_out_ready(data_out_ready), .br_cmd(br_cmd),
    .br_cmd_en(br_cmd_en), .br_addr(br_addr), .br_wr_data(br_wr_data), .br_busy(br_busy),
    .data_errors(data_errors), .protocol_errors(protocol_errors)
  );

  task automatic wait_reset_release();
    int n;
    n = 0;
    // rst is surely driven by the first falling edge
    @(negedge clk);
    while (rst && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (rst) begin
      $display("timeout: reset was never released");
      timeout_errors++;
    end
  endtask

  // busy is settled half a cycle after the accepting edge
  task automatic wait_idle();
    int n;
    n = 0;
    while (busy && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (busy) begin
      $display("timeout at %0t: busy still high after %0d cycles", $time, WAIT_LIMIT);
      timeout_errors++;
    end
  endtask

  // enable is a one-cycle strobe while the request fields hold until the next row
  task automatic apply_row(input row_t row);
    @(negedge clk);
    enable = 1'b1;
    command = row.is_write;
    address = row.addr;
    byte_en = row.be;
    data_in = row.is_write ? $urandom() : 32'h0;
    expect_hit = row.expect_hit;
    @(negedge clk);
    enable = 1'b0;
  endtask

  initial begin
    void'($urandom(81649));
    enable = 1'b0;
    command = 1'b0;
    address = '0;
    byte_en = '0;
    data_in = '0;
    expect_hit = 1'b0;
    timeout_errors = 0;
    wait_reset_release();
    for (int r = 0; r < ROWS && timeout_errors == 0; r++) begin
      apply_row(stim[r]);
      wait_idle();
    end
    // a last hit pulse still has to reach the checker
    @(negedge clk);
    @(negedge clk);
    $display("errors: data %0d, protocol %0d, timeout %0d",
             data_errors, protocol_errors, timeout_errors);
    if (data_errors + protocol_errors + timeout_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/tb_cache_checker.sv ====
// watches the request and burst RAM ports and compares against a shadow memory
// shadow covers the low 2 KB only, requests must stay below it
`timescale 1ns/1ps
`default_nettype none

module tb_cache_checker #(
  parameter logic [31:0] PRELOAD_KEY = 32'h0
) (
  input  wire                                      clk,
  input  wire                                      rst,
  input  wire                                      enable,
  input  wire                                      command,
  input  wire  [cache_geom_pkg::ADDR_WIDTH-1:0]    address,
  input  wire  cache_geom_pkg::byte_en_t           byte_en,
  input  wire  cache_geom_pkg::word_t              data_in,
  input  wire                                      expect_hit,
  input  wire                                      busy,
  input  wire  cache_geom_pkg::word_t              data_out,
  input  wire                                      data_out_ready,
  input  wire                                      br_cmd,
  input  wire                                      br_cmd_en,
  input  wire  [burst_ram_pkg::RAM_ADDR_WIDTH-1:0] br_addr,
  input  wire  burst_ram_pkg::beat_t               br_wr_data,
  input  wire                                      br_busy,
  output int                                       data_errors,
  output int                                       protocol_errors
);

  localparam int SHADOW_WORDS = 512;

  cache_geom_pkg::word_t shadow [SHADOW_WORDS];

  // last accepted read, waiting for its data_out_ready
  logic read_pending;
  cache_geom_pkg::word_t read_expect;
  // timing check one edge after acceptance
  logic due;
  logic due_hit;
  logic due_read;
  // write-back beats still to come
  int wb_left;
  logic [burst_ram_pkg::RAM_ADDR_WIDTH-1:0] wb_addr;
  logic rst_q;

  function automatic burst_ram_pkg::beat_t shadow_beat(
    input logic [burst_ram_pkg::RAM_ADDR_WIDTH-1:0] beat_addr
  );
    return {shadow[{beat_addr, 1'b1}], shadow[{beat_addr, 1'b0}]};
  endfunction

  function automatic cache_geom_pkg::word_t merge_bytes(
    input cache_geom_pkg::word_t old_word,
    input cache_geom_pkg::word_t new_word,
    input cache_geom_pkg::byte_en_t be
  );
    cache_geom_pkg::word_t result;
    result = old_word;
    for (int b = 0; b < cache_geom_pkg::WORD_BYTES; b++) begin
      if (be[b]) begin
        result[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return result;
  endfunction

  task automatic count_data_error(input string msg);
    $display("FAIL %0t: %s", $time, msg);
    data_errors++;
  endtask

  task automatic note_protocol_error(input string msg);
    $display("FAIL %0t: %s", $time, msg);
    protocol_errors++;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < SHADOW_WORDS; i++) begin
        shadow[i] = 32'(i * 4) ^ PRELOAD_KEY;
      end
      read_pending = 1'b0;
      due = 1'b0;
      wb_left = 0;
      rst_q = 1'b1;
      data_errors = 0;
      protocol_errors = 0;
    end else begin
      if (rst_q && (busy || data_out_ready || br_cmd_en)) begin
        note_protocol_error("outputs not idle after reset");
      end
      rst_q = 1'b0;
      if (br_cmd_en && br_busy) begin
        note_protocol_error("br_cmd_en pulse while br_busy high");
      end
      // hit or miss as the table expects
      if (due) begin
        if (due_hit && busy) begin
          note_protocol_error("busy rose on a hit");
        end
        if (!due_hit && !busy) begin
          note_protocol_error("busy did not rise on a miss");
        end
        if (due_hit && due_read && !data_out_ready) begin
          note_protocol_error("data_out_ready not one cycle after a read hit");
        end
        due = 1'b0;
      end
      if (data_out_ready) begin
        if (!read_pending) begin
          note_protocol_error("data_out_ready with no read outstanding");
        end else if (data_out !== read_expect) begin
          count_data_error($sformatf("read data %h, expected %h", data_out, read_expect));
        end
        read_pending = 1'b0;
      end
      // beats 1 to 3 follow the command on consecutive cycles
      if (wb_left > 0) begin
        if (br_wr_data !== shadow_beat(wb_addr)) begin
          count_data_error($sformatf("write-back beat at %h is %h, expected %h",
                                     wb_addr, br_wr_data, shadow_beat(wb_addr)));
        end
        wb_addr = wb_addr + 8'd1;
        wb_left--;
      end
      if (br_cmd_en && br_cmd) begin
        if (br_wr_data !== shadow_beat(br_addr)) begin
          count_data_error($sformatf("write-back beat at %h is %h, expected %h",
                                     br_addr, br_wr_data, shadow_beat(br_addr)));
        end
        wb_addr = br_addr + 8'd1;
        wb_left = burst_ram_pkg::BURST_LEN - 1;
      end
      if (enable && !busy) begin
        if (read_pending) begin
          note_protocol_error("previous read never got data_out_ready");
        end
        due = 1'b1;
        due_hit = expect_hit;
        due_read = !command;
        if (command) begin
          shadow[address[10:2]] = merge_bytes(shadow[address[10:2]], data_in, byte_en);
        end else begin
          read_pending = 1'b1;
          read_expect = shadow[address[10:2]];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb/tb_burst_ram.sv ====
// behavioral burst RAM of 256 beats with contents preloaded on reset
// each word holds its byte address XOR PRELOAD_KEY
`timescale 1ns/1ps
`default_nettype none

module tb_burst_ram #(
  parameter logic [31:0] PRELOAD_KEY = 32'h0
) (
  input  wire                                      clk,
  input  wire                                      rst,
  input  wire                                      br_cmd,
  input  wire                                      br_cmd_en,
  input  wire  [burst_ram_pkg::RAM_ADDR_WIDTH-1:0] br_addr,
  input  wire  burst_ram_pkg::beat_t               br_wr_data,
  output burst_ram_pkg::beat_t                     br_rd_data,
  output logic                                     br_rd_data_valid,
  output logic                                     br_busy
);

  localparam int DEPTH = 2 ** burst_ram_pkg::RAM_ADDR_WIDTH;

  burst_ram_pkg::beat_t mem [DEPTH];

  // burst in progress
  logic active;
  logic writing;
  logic [burst_ram_pkg::RAM_ADDR_WIDTH-1:0] base;
  int beat_no;
  // read latency still to go and quiet cycles left after a burst
  int delay_left;
  int cool_left;

  // quiet bus until the first reset edge
  initial begin
    br_rd_data = '0;
    br_rd_data_valid = 1'b0;
    br_busy = 1'b0;
  end

  always @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < DEPTH; k++) begin
        mem[k] <= {32'(k * 8 + 4) ^ PRELOAD_KEY, 32'(k * 8) ^ PRELOAD_KEY};
      end
      active <= 1'b0;
      writing <= 1'b0;
      base <= '0;
      beat_no <= 0;
      delay_left <= 0;
      cool_left <= 0;
      br_rd_data <= '0;
      br_rd_data_valid <= 1'b0;
      br_busy <= 1'b0;
    end else begin
      br_rd_data_valid <= 1'b0;
      if (br_cmd_en) begin
        active <= 1'b1;
        writing <= br_cmd;
        base <= br_addr;
        br_busy <= 1'b1;
        if (br_cmd) begin
          // beat 0 comes with the command
          mem[br_addr] <= br_wr_data;
          beat_no <= 1;
        end else begin
          beat_no <= 0;
          delay_left <= int'($urandom % 4);
        end
      end else if (active && writing) begin
        mem[base + 8'(beat_no)] <= br_wr_data;
        beat_no <= beat_no + 1;
        if (beat_no == burst_ram_pkg::BURST_LEN - 1) begin
          active <= 1'b0;
          cool_left <= 1 + int'($urandom % 3);
        end
      end else if (active && delay_left > 0) begin
        delay_left <= delay_left - 1;
      end else if (active) begin
        // four beats back to back
        br_rd_data_valid <= 1'b1;
        br_rd_data <= mem[base + 8'(beat_no)];
        beat_no <= beat_no + 1;
        if (beat_no == burst_ram_pkg::BURST_LEN - 1) begin
          active <= 1'b0;
          cool_left <= 1 + int'($urandom % 3);
        end
      end else if (cool_left > 0) begin
        cool_left <= cool_left - 1;
      end else begin
        br_busy <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
// 40 ns clock, rst held high over the first two rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // release on a falling edge like every other driven input
  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// ==== design/data_cache.sv ====
// write-back data cache in front of a burst RAM, one request at a time
// address, byte_en and data_in must stay stable while busy is high
// enable is a one-cycle strobe; requests during busy are ignored
`timescale 1ns/1ps
`default_nettype none

module data_cache (
  input  wire                                          clk,
  input  wire                                          rst,
  input  wire                                          enable,
  input  wire                                          command,
  input  wire  [cache_geom_pkg::ADDR_WIDTH-1:0]        address,
  input  wire  cache_geom_pkg::byte_en_t               byte_en,
  input  wire  cache_geom_pkg::word_t                  data_in,
  output cache_geom_pkg::word_t                        data_out,
  output logic                                         data_out_ready,
  output logic                                         busy,
  output logic                                         br_cmd,
  output logic                                         br_cmd_en,
  output logic [burst_ram_pkg::RAM_ADDR_WIDTH-1:0]     br_addr,
  output burst_ram_pkg::beat_t                         br_wr_data,
  input  wire  burst_ram_pkg::beat_t                   br_rd_data,
  input  wire                                          br_rd_data_valid,
  input  wire                                          br_busy
);

  // lookup to controller and line store
  logic hit;
  logic victim_dirty;
  logic [cache_geom_pkg::TAG_WIDTH-1:0] victim_tag;
  logic [cache_geom_pkg::LINE_IX_WIDTH-1:0] line_ix;
  logic [cache_geom_pkg::WORD_IX_WIDTH-1:0] word_ix;

  // controller to lookup and line store
  logic tag_fill;
  logic mark_dirty;
  logic fill_we;
  logic [burst_ram_pkg::BEAT_IX_WIDTH-1:0] beat_ix;
  logic merge_we;
  logic hit_read;
  logic [burst_ram_pkg::BEAT_IX_WIDTH-1:0] wb_beat_ix;

  // line store back to controller
  burst_ram_pkg::beat_t wb_beat;

  cache_tag_lookup tag_lookup_i (
    .clk          (clk),
    .rst          (rst),
    .address      (address),
    .tag_fill     (tag_fill),
    .mark_dirty   (mark_dirty),
    .hit          (hit),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag),
    .line_ix      (line_ix),
    .word_ix      (word_ix)
  );

  cache_controller controller_i (
    .clk              (clk),
    .rst              (rst),
    .enable           (enable),
    .command          (command),
    .address          (address),
    .hit              (hit),
    .victim_dirty     (victim_dirty),
    .victim_tag       (victim_tag),
    .line_ix          (line_ix),
    .wb_beat          (wb_beat),
    .br_rd_data_valid (br_rd_data_valid),
    .br_busy          (br_busy),
    .busy             (busy),
    .tag_fill         (tag_fill),
    .mark_dirty       (mark_dirty),
    .fill_we          (fill_we),
    .beat_ix          (beat_ix),
    .merge_we         (merge_we),
    .hit_read         (hit_read),
    .wb_beat_ix       (wb_beat_ix),
    .br_cmd           (br_cmd),
    .br_cmd_en        (br_cmd_en),
    .br_addr          (br_addr),
    .br_wr_data       (br_wr_data)
  );

  cache_line_store line_store_i (
    .clk            (clk),
    .rst            (rst),
    .line_ix        (line_ix),
    .word_ix        (word_ix),
    .fill_we        (fill_we),
    .beat_ix        (beat_ix),
    .br_rd_data     (br_rd_data),
    .merge_we       (merge_we),
    .byte_en        (byte_en),
    .data_in        (data_in),
    .hit_read       (hit_read),
    .wb_beat_ix     (wb_beat_ix),
    .wb_beat        (wb_beat),
    .data_out       (data_out),
    .data_out_ready (data_out_ready)
  );

endmodule

`default_nettype wire

// ==== design/cache_line_store.sv ====
// line data array, fill by beats, byte merge and the read result register
// a request with no byte enables is treated as a read when its beat arrives
`timescale 1ns/1ps
`default_nettype none

module cache_line_store (
  input  wire                                          clk,
  input  wire                                          rst,
  input  wire  [cache_geom_pkg::LINE_IX_WIDTH-1:0]     line_ix,
  input  wire  [cache_geom_pkg::WORD_IX_WIDTH-1:0]     word_ix,
  input  wire                                          fill_we,
  input  wire  [burst_ram_pkg::BEAT_IX_WIDTH-1:0]      beat_ix,
  input  wire  burst_ram_pkg::beat_t                   br_rd_data,
  input  wire                                          merge_we,
  input  wire  cache_geom_pkg::byte_en_t               byte_en,
  input  wire  cache_geom_pkg::word_t                  data_in,
  input  wire                                          hit_read,
  input  wire  [burst_ram_pkg::BEAT_IX_WIDTH-1:0]      wb_beat_ix,
  output burst_ram_pkg::beat_t                         wb_beat,
  output cache_geom_pkg::word_t                        data_out,
  output logic                                         data_out_ready
);

  // word position inside a beat
  localparam int SEL_WIDTH = cache_geom_pkg::WORD_IX_WIDTH - burst_ram_pkg::BEAT_IX_WIDTH;
  localparam int WW = cache_geom_pkg::WORD_WIDTH;

  cache_geom_pkg::word_t line_mem [cache_geom_pkg::LINE_COUNT][cache_geom_pkg::WORDS_PER_LINE];

  logic [SEL_WIDTH-1:0] word_sel;
  logic fill_read;

  assign word_sel = word_ix[SEL_WIDTH-1:0];

  // requested word travels in the beat being filled, and it is a read
  assign fill_read = fill_we && (byte_en == '0) &&
                     (word_ix[cache_geom_pkg::WORD_IX_WIDTH-1 -:
                              burst_ram_pkg::BEAT_IX_WIDTH] == beat_ix);

  // beat for write-back, lower word in the low half
  always_comb begin
    for (int i = 0; i < burst_ram_pkg::WORDS_PER_BEAT; i++) begin
      wb_beat[i*WW +: WW] = line_mem[line_ix][{wb_beat_ix, SEL_WIDTH'(i)}];
    end
  end

  always_ff @(posedge clk) begin
    if (fill_we) begin
      for (int i = 0; i < burst_ram_pkg::WORDS_PER_BEAT; i++) begin
        line_mem[line_ix][{beat_ix, SEL_WIDTH'(i)}] <= br_rd_data[i*WW +: WW];
      end
    end
    // never in the same cycle as a fill
    if (merge_we) begin
      for (int b = 0; b < cache_geom_pkg::WORD_BYTES; b++) begin
        if (byte_en[b]) begin
          line_mem[line_ix][word_ix][b*8 +: 8] <= data_in[b*8 +: 8];
        end
      end
    end
  end

  // read result, straight from the RAM beat on a miss
  always_ff @(posedge clk) begin
    if (hit_read) begin
      data_out <= line_mem[line_ix][word_ix];
    end else if (fill_read) begin
      for (int i = 0; i < burst_ram_pkg::WORDS_PER_BEAT; i++) begin
        if (word_sel == SEL_WIDTH'(i)) begin
          data_out <= br_rd_data[i*WW +: WW];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      data_out_ready <= 1'b0;
    end else begin
      data_out_ready <= hit_read || fill_read;
    end
  end

endmodule

`default_nettype wire

// ==== design/cache_controller.sv ====
// one request in flight; a miss holds busy until the line is fetched and merged
// br_cmd_en is combinational on br_busy so a command never starts while the RAM is busy
`timescale 1ns/1ps
`default_nettype none

module cache_controller (
  input  wire                                          clk,
  input  wire                                          rst,
  input  wire                                          enable,
  input  wire                                          command,
  input  wire  [cache_geom_pkg::ADDR_WIDTH-1:0]        address,
  input  wire                                          hit,
  input  wire                                          victim_dirty,
  input  wire  [cache_geom_pkg::TAG_WIDTH-1:0]         victim_tag,
  input  wire  [cache_geom_pkg::LINE_IX_WIDTH-1:0]     line_ix,
  input  wire  burst_ram_pkg::beat_t                   wb_beat,
  input  wire                                          br_rd_data_valid,
  input  wire                                          br_busy,
  output logic                                         busy,
  output logic                                         tag_fill,
  output logic                                         mark_dirty,
  output logic                                         fill_we,
  output logic [burst_ram_pkg::BEAT_IX_WIDTH-1:0]      beat_ix,
  output logic                                         merge_we,
  output logic                                         hit_read,
  output logic [burst_ram_pkg::BEAT_IX_WIDTH-1:0]      wb_beat_ix,
  output logic                                         br_cmd,
  output logic                                         br_cmd_en,
  output logic [burst_ram_pkg::RAM_ADDR_WIDTH-1:0]     br_addr,
  output burst_ram_pkg::beat_t                         br_wr_data
);

  localparam int BIW = burst_ram_pkg::BEAT_IX_WIDTH;
  localparam logic [BIW-1:0] LAST_BEAT = BIW'(burst_ram_pkg::BURST_LEN - 1);
  // byte offset of a word within a line
  localparam int LINE_OFFSET_WIDTH =
    cache_geom_pkg::WORD_IX_WIDTH + cache_geom_pkg::BYTE_OFFSET_WIDTH;

  cache_geom_pkg::ctrl_state_t state;

  // beat counter, shared by write-back and fetch
  logic [BIW-1:0] beat_cnt;

  // request latched at acceptance
  logic req_cmd_q;
  logic [cache_geom_pkg::ADDR_WIDTH-1:0] req_addr_q;

  logic accept;

  // beat address of the first beat of the line holding byte_addr
  function automatic logic [burst_ram_pkg::RAM_ADDR_WIDTH-1:0] line_beat_addr(
    input logic [cache_geom_pkg::ADDR_WIDTH-1:0] byte_addr
  );
    logic [cache_geom_pkg::ADDR_WIDTH-1:0] line_base;
    line_base = {byte_addr[cache_geom_pkg::ADDR_WIDTH-1:LINE_OFFSET_WIDTH],
                 {LINE_OFFSET_WIDTH{1'b0}}};
    return line_base[burst_ram_pkg::BEAT_SHIFT +: burst_ram_pkg::RAM_ADDR_WIDTH];
  endfunction

  always_comb begin
    accept = enable && (state == cache_geom_pkg::ST_IDLE);
    busy = (state != cache_geom_pkg::ST_IDLE);
    // hits are served on the accepting edge
    hit_read = accept && hit && !command;
    merge_we = (accept && hit && command) ||
               ((state == cache_geom_pkg::ST_FINISH) && req_cmd_q);
    mark_dirty = merge_we;
    br_cmd_en = ((state == cache_geom_pkg::ST_WB_ISSUE) ||
                 (state == cache_geom_pkg::ST_FETCH_ISSUE)) && !br_busy;
    // new tag goes in as soon as the fetch is committed
    tag_fill = (state == cache_geom_pkg::ST_FETCH_ISSUE) && !br_busy;
    fill_we = ((state == cache_geom_pkg::ST_FETCH_WAIT) ||
               (state == cache_geom_pkg::ST_FETCH_BEATS)) && br_rd_data_valid;
    beat_ix = beat_cnt;
    // idle preloads beat 0, afterwards always one beat ahead of the bus
    wb_beat_ix = (state == cache_geom_pkg::ST_IDLE) ? '0 : beat_cnt + BIW'(1);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= cache_geom_pkg::ST_IDLE;
      beat_cnt <= '0;
      req_cmd_q <= 1'b0;
    end else begin
      case (state)
        cache_geom_pkg::ST_IDLE: begin
          beat_cnt <= '0;
          if (accept && !hit) begin
            req_cmd_q <= command;
            if (victim_dirty) begin
              state <= cache_geom_pkg::ST_WB_ISSUE;
            end else begin
              state <= cache_geom_pkg::ST_FETCH_ISSUE;
            end
          end
        end

        // wait out br_busy, beat 0 already sits on br_wr_data
        cache_geom_pkg::ST_WB_ISSUE: begin
          if (!br_busy) begin
            beat_cnt <= beat_cnt + BIW'(1);
            state <= cache_geom_pkg::ST_WB_BEATS;
          end
        end

        // beat_cnt is the beat currently on the bus
        cache_geom_pkg::ST_WB_BEATS: begin
          if (beat_cnt == LAST_BEAT) begin
            beat_cnt <= '0;
            state <= cache_geom_pkg::ST_FETCH_ISSUE;
          end else begin
            beat_cnt <= beat_cnt + BIW'(1);
          end
        end

        cache_geom_pkg::ST_FETCH_ISSUE: begin
          if (!br_busy) begin
            state <= cache_geom_pkg::ST_FETCH_WAIT;
          end
        end

        // read delay from the RAM varies
        cache_geom_pkg::ST_FETCH_WAIT: begin
          if (br_rd_data_valid) begin
            beat_cnt <= beat_cnt + BIW'(1);
            state <= cache_geom_pkg::ST_FETCH_BEATS;
          end
        end

        cache_geom_pkg::ST_FETCH_BEATS: begin
          if (br_rd_data_valid) begin
            beat_cnt <= beat_cnt + BIW'(1);
            if (beat_cnt == LAST_BEAT) begin
              state <= cache_geom_pkg::ST_FINISH;
            end
          end
        end

        // write merge happens here, line is complete
        cache_geom_pkg::ST_FINISH: begin
          state <= cache_geom_pkg::ST_IDLE;
        end

        default: begin
          state <= cache_geom_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // burst command payload
  always_ff @(posedge clk) begin
    if (state == cache_geom_pkg::ST_IDLE) begin
      req_addr_q <= address;
      // victim beat 0, only used if this turns into an eviction
      br_wr_data <= wb_beat;
      if (victim_dirty) begin
        br_cmd <= 1'b1;
        br_addr <= line_beat_addr({victim_tag, line_ix, {LINE_OFFSET_WIDTH{1'b0}}});
      end else begin
        br_cmd <= 1'b0;
        br_addr <= line_beat_addr(address);
      end
    end else if ((state == cache_geom_pkg::ST_WB_ISSUE) && !br_busy) begin
      br_wr_data <= wb_beat;
    end else if (state == cache_geom_pkg::ST_WB_BEATS) begin
      if (beat_cnt == LAST_BEAT) begin
        // switch over to the fetch of the requested line
        br_cmd <= 1'b0;
        br_addr <= line_beat_addr(req_addr_q);
      end else begin
        br_wr_data <= wb_beat;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/cache_tag_lookup.sv ====
// tag, valid and dirty state per line; hit decision is purely combinational
// dirty is only meaningful while the line is valid
`timescale 1ns/1ps
`default_nettype none

module cache_tag_lookup (
  input  wire                                          clk,
  input  wire                                          rst,
  input  wire  [cache_geom_pkg::ADDR_WIDTH-1:0]        address,
  input  wire                                          tag_fill,
  input  wire                                          mark_dirty,
  output logic                                         hit,
  output logic                                         victim_dirty,
  output logic [cache_geom_pkg::TAG_WIDTH-1:0]         victim_tag,
  output logic [cache_geom_pkg::LINE_IX_WIDTH-1:0]     line_ix,
  output logic [cache_geom_pkg::WORD_IX_WIDTH-1:0]     word_ix
);

  logic [cache_geom_pkg::TAG_WIDTH-1:0] req_tag;

  // one bit per line
  logic [cache_geom_pkg::LINE_COUNT-1:0] valid_q;
  logic [cache_geom_pkg::LINE_COUNT-1:0] dirty_q;

  // stored tags, meaningless until the valid bit is set
  logic [cache_geom_pkg::TAG_WIDTH-1:0] tag_mem [cache_geom_pkg::LINE_COUNT];

  // split the byte address, low two bits dropped
  assign req_tag = address[cache_geom_pkg::ADDR_WIDTH-1 -: cache_geom_pkg::TAG_WIDTH];
  assign line_ix = address[cache_geom_pkg::BYTE_OFFSET_WIDTH + cache_geom_pkg::WORD_IX_WIDTH +:
                           cache_geom_pkg::LINE_IX_WIDTH];
  assign word_ix = address[cache_geom_pkg::BYTE_OFFSET_WIDTH +: cache_geom_pkg::WORD_IX_WIDTH];

  // current occupant of the indexed line
  assign victim_tag = tag_mem[line_ix];
  assign victim_dirty = valid_q[line_ix] && dirty_q[line_ix];

  assign hit = valid_q[line_ix] && (tag_mem[line_ix] == req_tag);

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (tag_fill) begin
      // new line arrives clean
      valid_q[line_ix] <= 1'b1;
      dirty_q[line_ix] <= 1'b0;
    end else if (mark_dirty) begin
      dirty_q[line_ix] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (tag_fill) begin
      tag_mem[line_ix] <= req_tag;
    end
  end

endmodule

`default_nettype wire

// ==== design/burst_ram_pkg.sv ====
// burst RAM side, one burst of four 64-bit beats moves one cache line
`default_nettype none

package burst_ram_pkg;

  localparam int BEAT_WIDTH = 64;
  localparam int WORDS_PER_BEAT = 2;
  localparam int BURST_LEN = 4;

  // RAM addresses count beats, 256 beats give 2 KB
  localparam int RAM_ADDR_WIDTH = 8;
  // byte address >> 3 gives the beat address
  localparam int BEAT_SHIFT = 3;
  localparam int BEAT_IX_WIDTH = $clog2(BURST_LEN);

  typedef logic [BEAT_WIDTH-1:0] beat_t;

endpackage

`default_nettype wire

// ==== design/cache_geom_pkg.sv ====
// geometry of the direct-mapped cache and its controller state encoding
// one cache line must hold exactly one burst of burst_ram_pkg
`default_nettype none

package cache_geom_pkg;

  // request side, byte addressed, words aligned to 4 bytes
  localparam int ADDR_WIDTH = 32;
  localparam int WORD_WIDTH = 32;
  localparam int WORD_BYTES = WORD_WIDTH / 8;
  localparam int BYTE_OFFSET_WIDTH = 2;

  // 8 words per line, 2 lines
  localparam int WORD_IX_WIDTH = 3;
  localparam int LINE_IX_WIDTH = 1;
  localparam int LINE_COUNT = 2 ** LINE_IX_WIDTH;
  localparam int WORDS_PER_LINE = 2 ** WORD_IX_WIDTH;

  // address layout is |tag|line|word|00|
  localparam int TAG_WIDTH = ADDR_WIDTH - LINE_IX_WIDTH - WORD_IX_WIDTH - BYTE_OFFSET_WIDTH;

  typedef logic [WORD_WIDTH-1:0] word_t;
  typedef logic [WORD_BYTES-1:0] byte_en_t;

  // miss sequencing, write-back first when the victim is dirty
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WB_ISSUE,
    ST_WB_BEATS,
    ST_FETCH_ISSUE,
    ST_FETCH_WAIT,
    ST_FETCH_BEATS,
    ST_FINISH
  } ctrl_state_t;

endpackage

`default_nettype wire
